/* hdl/rom_pkg.sv */
package rom_pkg;

    // SDRAM word address, 16-bit words
    localparam int sdram_aw = 22;

    // One read returns two words
    localparam int sdram_dw = 32;

    // ROM hub arbiter states
    typedef enum logic [1:0] {
        idle,       // Waiting for a slot request
        wait_ack,   // Request out, held until ack
        wait_data   // Ack seen, waiting for data_rdy
    } hub_state_t;

    // Slot names, in priority order
    typedef enum logic [1:0] {
        gfx1,
        gfx2,
        snd,
        main
    } slot_id_t;

endpackage

/* hdl/cen_gen.sv */
module cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic cen12,   // 12 MHz pixel enable
    output logic cen6     // 6 MHz pixel enable
);

    logic [1:0] cnt;

    // Enables registered from the count so both stay low right after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= 2'd0;
            cen12 <= 1'b0;
            cen6  <= 1'b0;
        end else begin
            cnt   <= cnt + 2'd1;
            cen12 <= cnt[0];
            cen6  <= &cnt;   // Once per wrap
        end
    end

endmodule

/* hdl/rom_dwnld.sv */
module rom_dwnld #(
    parameter logic [24:0] prom_start = 25'h128000
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         downloading,
    input  logic [24:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    input  logic                         ioctl_wr,
    input  logic                         sdram_ack,
    output logic [rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,  // Active low
    output logic                         prog_we,
    output logic                         prom_we
);

    import rom_pkg::*;

    logic        wr_ok;
    logic        is_prom;
    logic [24:0] prom_off;

    assign wr_ok    = ioctl_wr && downloading;
    assign is_prom  = ioctl_addr >= prom_start;
    assign prom_off = ioctl_addr - prom_start;

    // Write strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr_ok && is_prom;   // Single pulse
            if (wr_ok && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;   // Held until the controller takes it
            end
        end
    end

    // Address, data and byte mask
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            prog_data <= ioctl_data;
            if (is_prom) begin
                prog_addr <= prom_off[sdram_aw-1:0];
            end else begin
                prog_addr <= ioctl_addr[sdram_aw:1];
            end
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Odd byte goes high
        end
    end

endmodule

/* hdl/rom_slot.sv */
module rom_slot #(
    parameter int                          aw     = 18,
    parameter int                          dw     = 16,
    parameter logic [rom_pkg::sdram_aw-1:0] offset = '0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         clr,
    input  logic                         cs,
    input  logic [aw-1:0]                addr,
    output logic                         ok,
    output logic [dw-1:0]                data,
    output logic                         req,
    output logic [rom_pkg::sdram_aw-1:0] req_addr,
    input  logic                         fill,
    input  logic [rom_pkg::sdram_dw-1:0] fill_data
);

    import rom_pkg::*;

    // Address bits that pick a byte or word inside the 32-bit line
    localparam int sel_w = (dw == 8) ? 2 : 1;
    localparam int tag_w = aw - sel_w;

    logic [sdram_dw-1:0] line;
    logic [tag_w-1:0]    line_tag;
    logic                valid;
    logic                hit;
    logic                ok_q;

    assign hit = valid && (line_tag == addr[aw-1:sel_w]);
    assign req = cs && !hit;

    // First word of the line, always even
    assign req_addr = offset + sdram_aw'({addr[aw-1:sel_w], 1'b0});

    // Low half of the line holds the lower address
    assign data = line[dw*addr[sel_w-1:0] +: dw];

    assign ok = ok_q && !clr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            ok_q  <= 1'b0;
        end else if (clr) begin
            valid <= 1'b0;
            ok_q  <= 1'b0;
        end else begin
            if (fill) begin
                valid <= 1'b1;
            end
            ok_q <= cs && (hit || fill);   // Fill is always for the held addr
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            line     <= fill_data;
            line_tag <= addr[aw-1:sel_w];
        end
    end

endmodule

/* hdl/rom_hub.sv */
module rom_hub #(
    parameter int                           gfx1_aw     = 18,
    parameter int                           gfx1_dw     = 16,
    parameter logic [rom_pkg::sdram_aw-1:0] gfx1_offset = '0,
    parameter int                           gfx2_aw     = 18,
    parameter int                           gfx2_dw     = 16,
    parameter logic [rom_pkg::sdram_aw-1:0] gfx2_offset = '0,
    parameter int                           snd_aw      = 15,
    parameter int                           snd_dw      = 8,
    parameter logic [rom_pkg::sdram_aw-1:0] snd_offset  = '0,
    parameter int                           main_aw     = 17,
    parameter int                           main_dw     = 8,
    parameter logic [rom_pkg::sdram_aw-1:0] main_offset = '0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         downloading,
    input  logic                         loop_rst,
    input  logic                         gfx1_cs,
    input  logic [gfx1_aw-1:0]           gfx1_addr,
    output logic                         gfx1_ok,
    output logic [gfx1_dw-1:0]           gfx1_data,
    input  logic                         gfx2_cs,
    input  logic [gfx2_aw-1:0]           gfx2_addr,
    output logic                         gfx2_ok,
    output logic [gfx2_dw-1:0]           gfx2_data,
    input  logic                         snd_cs,
    input  logic [snd_aw-1:0]            snd_addr,
    output logic                         snd_ok,
    output logic [snd_dw-1:0]            snd_data,
    input  logic                         main_cs,
    input  logic [main_aw-1:0]           main_addr,
    output logic                         main_ok,
    output logic [main_dw-1:0]           main_data,
    output logic                         sdram_req,
    output logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  logic [rom_pkg::sdram_dw-1:0] data_read,
    output logic                         refresh_en
);

    import rom_pkg::*;

    hub_state_t          state;
    slot_id_t            grant;
    slot_id_t            pick;
    logic                clr;
    logic [3:0]          req;
    logic [3:0]          fill;
    logic [sdram_aw-1:0] req_addr [4];

    assign clr        = downloading || loop_rst;
    assign refresh_en = (state == idle) && (req == 4'd0);

    // Fixed priority, lowest index wins
    always_comb begin
        if (req[gfx1]) pick = gfx1;
        else if (req[gfx2]) pick = gfx2;
        else if (req[snd]) pick = snd;
        else pick = main;
    end

    always_comb begin
        fill = 4'd0;
        if (state == wait_data && data_rdy) begin
            fill[grant] = 1'b1;   // Back to the slot that asked
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            grant     <= gfx1;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                idle: if (!downloading && req != 4'd0) begin
                    grant     <= pick;
                    sdram_req <= 1'b1;
                    state     <= wait_ack;
                end
                wait_ack: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= wait_data;
                end
                wait_data: if (data_rdy) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Address is frozen from grant until the next idle
    always_ff @(posedge clk) begin
        if (state == idle) sdram_addr <= req_addr[pick];
    end

    rom_slot #(.aw(gfx1_aw), .dw(gfx1_dw), .offset(gfx1_offset)) u_gfx1 (
        .clk(clk), .rst_n(rst_n), .clr(clr),
        .cs(gfx1_cs), .addr(gfx1_addr), .ok(gfx1_ok), .data(gfx1_data),
        .req(req[gfx1]), .req_addr(req_addr[gfx1]),
        .fill(fill[gfx1]), .fill_data(data_read)
    );

    rom_slot #(.aw(gfx2_aw), .dw(gfx2_dw), .offset(gfx2_offset)) u_gfx2 (
        .clk(clk), .rst_n(rst_n), .clr(clr),
        .cs(gfx2_cs), .addr(gfx2_addr), .ok(gfx2_ok), .data(gfx2_data),
        .req(req[gfx2]), .req_addr(req_addr[gfx2]),
        .fill(fill[gfx2]), .fill_data(data_read)
    );

    rom_slot #(.aw(snd_aw), .dw(snd_dw), .offset(snd_offset)) u_snd (
        .clk(clk), .rst_n(rst_n), .clr(clr),
        .cs(snd_cs), .addr(snd_addr), .ok(snd_ok), .data(snd_data),
        .req(req[snd]), .req_addr(req_addr[snd]),
        .fill(fill[snd]), .fill_data(data_read)
    );

    rom_slot #(.aw(main_aw), .dw(main_dw), .offset(main_offset)) u_main (
        .clk(clk), .rst_n(rst_n), .clr(clr),
        .cs(main_cs), .addr(main_addr), .ok(main_ok), .data(main_data),
        .req(req[main]), .req_addr(req_addr[main]),
        .fill(fill[main]), .fill_data(data_read)
    );

endmodule

/* hdl/arcade_game.sv */
module arcade_game #(
    parameter logic [24:0]                  prom_start  = 25'h128000,
    parameter logic [rom_pkg::sdram_aw-1:0] snd_offset  = 22'h2_0000 >> 1,
    parameter logic [rom_pkg::sdram_aw-1:0] gfx1_offset = snd_offset + (22'h0_8000 >> 1),
    parameter logic [rom_pkg::sdram_aw-1:0] gfx2_offset = gfx1_offset + (22'h8_0000 >> 1)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         pxl2_cen,   // 12 MHz
    output logic                         pxl_cen,    // 6 MHz
    // ROM requesters
    input  logic                         gfx1_cs,
    input  logic [17:0]                  gfx1_addr,
    output logic                         gfx1_ok,
    output logic [15:0]                  gfx1_data,
    input  logic                         gfx2_cs,
    input  logic [17:0]                  gfx2_addr,
    output logic                         gfx2_ok,
    output logic [15:0]                  gfx2_data,
    input  logic                         snd_cs,
    input  logic [14:0]                  snd_addr,
    output logic                         snd_ok,
    output logic [7:0]                   snd_data,
    input  logic                         main_cs,
    input  logic [16:0]                  main_addr,
    output logic                         main_ok,
    output logic [7:0]                   main_data,
    // SDRAM read port
    output logic                         sdram_req,
    output logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  logic [rom_pkg::sdram_dw-1:0] data_read,
    output logic                         refresh_en,
    input  logic                         downloading,
    input  logic                         loop_rst,
    // ROM load
    input  logic [24:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    input  logic                         ioctl_wr,
    output logic [rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    output logic                         prom_we
);

    cen_gen u_cen (
        .clk   (clk),
        .rst_n (rst_n),
        .cen12 (pxl2_cen),
        .cen6  (pxl_cen)
    );

    rom_dwnld #(.prom_start(prom_start)) u_dwnld (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_hub #(
        .gfx1_aw(18), .gfx1_dw(16), .gfx1_offset(gfx1_offset),
        .gfx2_aw(18), .gfx2_dw(16), .gfx2_offset(gfx2_offset),
        .snd_aw (15), .snd_dw (8),  .snd_offset (snd_offset),
        .main_aw(17), .main_dw(8),  .main_offset(22'd0)   // Main CPU ROM at the bottom
    ) u_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .gfx1_cs     (gfx1_cs),
        .gfx1_addr   (gfx1_addr),
        .gfx1_ok     (gfx1_ok),
        .gfx1_data   (gfx1_data),
        .gfx2_cs     (gfx2_cs),
        .gfx2_addr   (gfx2_addr),
        .gfx2_ok     (gfx2_ok),
        .gfx2_data   (gfx2_data),
        .snd_cs      (snd_cs),
        .snd_addr    (snd_addr),
        .snd_ok      (snd_ok),
        .snd_data    (snd_data),
        .main_cs     (main_cs),
        .main_addr   (main_addr),
        .main_ok     (main_ok),
        .main_data   (main_data),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .refresh_en  (refresh_en)
    );

endmodule

/* dv/tb_checker.sv */
module tb_checker #(
    parameter int n_line = 6
) (
    input  logic        clk,
    input  logic        rst_n,
    input  int          phase,
    input  logic        pxl2_cen,
    input  logic        pxl_cen,
    input  logic        gfx1_cs, gfx2_cs, snd_cs, main_cs,
    input  logic        gfx1_ok, gfx2_ok, snd_ok, main_ok,
    input  logic [17:0] gfx1_addr, gfx2_addr,
    input  logic [14:0] snd_addr,
    input  logic [16:0] main_addr,
    input  logic [15:0] gfx1_data, gfx2_data,
    input  logic [7:0]  snd_data, main_data,
    input  logic        sdram_req, sdram_ack, data_rdy,
    input  logic [21:0] sdram_addr,
    input  logic        refresh_en,
    input  logic        downloading, loop_rst, ioctl_wr,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic [21:0] prog_addr,
    input  logic [7:0]  prog_data,
    input  logic [1:0]  prog_mask,
    input  logic        prog_we, prom_we,
    output int          errors,
    output int          checks
);
    timeunit 1ns;
    timeprecision 1ps;

    import rom_pkg::*;

    localparam logic [24:0] prom_start = 25'h128000;
    localparam logic [21:0] snd_off  = 22'h10000;
    localparam logic [21:0] gfx1_off = 22'h14000;
    localparam logic [21:0] gfx2_off = 22'h54000;

    int          n_cyc, cur, t_chk, t_err, fetches, exp_i;
    logic [3:0]  cs_v, ok_v, pend, pend_q, line_ok;
    logic [21:0] wa [4];
    logic [21:0] line_at [4];
    logic [21:0] want_q [4];
    logic [15:0] act [4];
    logic [15:0] exp_d [4];
    logic [15:0] w;
    logic [3:0]  bsel;
    logic        req_q, ack_q, wr_q, wr_prom_q, prog_pend;
    logic        data_wait;
    logic [24:0] wr_addr_q;
    logic [7:0]  wr_data_q;
    logic [1:0]  exp_mask;
    slot_id_t    sid;

    function automatic string tname(input int p);
        case (p)
            1: return "reset";
            2: return "prog_load";
            3: return "prom_load";
            4: return "random_read";
            5: return "line_reuse";
            default: return "download_block";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act_v);
        checks++;
        t_chk++;
        if (exp !== act_v) begin
            errors++;
            t_err++;
            $display("ERR %s expected %h actual %h", name, exp, act_v);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            {n_cyc, cur, t_chk, t_err, fetches, errors, checks} = '0;
            {req_q, ack_q, wr_q, wr_prom_q, prog_pend} = '0;
            data_wait = 1'b0;
            pend_q    = '0;
            line_ok   = '0;
        end else begin
            n_cyc++;
            if (phase != cur) begin
                if (cur == 5) check_val("line_reuse_fetches", 2 * n_line, fetches);
                if (cur >= 1 && cur <= 6)
                    $display("test %s done, %0d checks, %0d errors", tname(cur), t_chk, t_err);
                cur     = phase;
                t_chk   = 0;
                t_err   = 0;
                fetches = 0;
            end
            // Values seen here were set by edge n_cyc-1
            check_val("pxl2_cen", ((n_cyc - 1) % 2 == 0) && (n_cyc > 1), pxl2_cen);
            check_val("pxl_cen", ((n_cyc - 1) % 4 == 0) && (n_cyc > 1), pxl_cen);

            cs_v = {main_cs, snd_cs, gfx2_cs, gfx1_cs};   // Indexed by slot id
            ok_v = {main_ok, snd_ok, gfx2_ok, gfx1_ok};
            if (cur == 1) check_val("reset_quiet", 0, {sdram_req, prog_we, prom_we, ok_v});
            if (cur == 2 || cur == 3 || cur == 6)
                check_val({tname(cur), "_no_read"}, 0, {sdram_req, ok_v});
            if (cur == 3) check_val("prom_no_prog_we", 0, prog_we);

            // Loader writes
            if (wr_q && wr_prom_q) begin
                check_val("prom_we", 2'b10, {prom_we, prog_we});
                check_val("prom_addr", 22'(wr_addr_q - prom_start), prog_addr);
                check_val("prom_data", wr_data_q, prog_data);
            end else if (wr_q) begin
                exp_mask = ~(2'b01 << wr_addr_q[0]);   // Active low, one lane per byte
                check_val("prog_we", 2'b10, {prog_we, prom_we});
                check_val("prog_addr", 22'(wr_addr_q >> 1), prog_addr);
                check_val("prog_data", wr_data_q, prog_data);
                check_val("prog_mask", exp_mask, prog_mask);
                prog_pend = 1'b1;
            end else begin
                check_val("prom_we_idle", 0, prom_we);
                if (prog_pend && ack_q) begin
                    check_val("prog_we_release", 0, prog_we);
                    prog_pend = 1'b0;
                end else if (prog_pend) begin
                    check_val("prog_we_hold", 1, prog_we);
                end
            end
            wr_q      = ioctl_wr && downloading;
            wr_prom_q = ioctl_addr >= prom_start;
            wr_addr_q = ioctl_addr;
            wr_data_q = ioctl_data;
            ack_q     = sdram_ack;

            // Read model, word address and expected data per slot
            wa[0]  = gfx1_off + 22'(gfx1_addr);
            wa[1]  = gfx2_off + 22'(gfx2_addr);
            wa[2]  = snd_off + 22'(snd_addr >> 1);
            wa[3]  = 22'(main_addr >> 1);
            bsel   = {main_addr[0], snd_addr[0], 2'b00};
            act[0] = gfx1_data;
            act[1] = gfx2_data;
            act[2] = {8'h00, snd_data};
            act[3] = {8'h00, main_data};
            for (int i = 0; i < 4; i++) begin
                w = wa[i][15:0] ^ 16'ha5c3;
                if (i < 2) exp_d[i] = w;
                else exp_d[i] = bsel[i] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
                if (ok_v[i]) begin   // Requester has already dropped cs here
                    sid = slot_id_t'(i);
                    check_val({"read_", sid.name()}, exp_d[i], act[i]);
                    line_ok[i] = 1'b1;
                    line_at[i] = wa[i] & ~22'd1;
                end
                if (loop_rst || downloading) line_ok[i] = 1'b0;
                pend[i] = cs_v[i] && !(line_ok[i] && line_at[i] == (wa[i] & ~22'd1));
            end

            // Hub busy from the request until data comes back
            check_val("refresh_en", !(sdram_req || data_wait) && pend == 4'd0, refresh_en);
            if (data_rdy) data_wait = 1'b0;
            if (sdram_req && sdram_ack) data_wait = 1'b1;

            // New fetch must serve the highest-priority pending slot
            if (sdram_req && !req_q) begin
                fetches++;
                exp_i = -1;
                for (int i = 3; i >= 0; i--) if (pend_q[i]) exp_i = i;
                if (exp_i < 0) begin
                    errors++;
                    t_err++;
                    $display("sdram_req rose while no slot was waiting for data");
                end else begin
                    check_val("priority_addr", want_q[exp_i], sdram_addr);
                end
            end
            for (int i = 0; i < 4; i++) want_q[i] = wa[i] & ~22'd1;
            pend_q = pend;
            req_q  = sdram_req;
        end
    end

endmodule

/* dv/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [24:0] prom_start = 25'h128000;
    localparam int n_prog  = 32;
    localparam int n_prom  = 8;
    localparam int n_reads = 20;
    localparam int n_line  = 6;
    localparam int n_dl    = 40;
    // Each read, load or line step counts as one item
    localparam int n_items = n_prog + n_prom + 4 * n_reads + 3 * n_line + n_dl / 4;
    localparam int limit   = n_items * 40;

    logic        clk, rst_n, pxl2_cen, pxl_cen, refresh_en;
    logic        gfx1_cs, gfx2_cs, snd_cs, main_cs;
    logic        gfx1_ok, gfx2_ok, snd_ok, main_ok;
    logic [17:0] gfx1_addr, gfx2_addr;
    logic [14:0] snd_addr;
    logic [16:0] main_addr;
    logic [15:0] gfx1_data, gfx2_data;
    logic [7:0]  snd_data, main_data;
    logic        sdram_req, sdram_ack, data_rdy, downloading, loop_rst, ioctl_wr;
    logic [21:0] sdram_addr, prog_addr;
    logic [31:0] data_read;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data, prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we, prom_we;
    int          phase, errors, checks;
    integer      seed;

    arcade_game u_dut (.*);

    tb_checker #(.n_line(n_line)) u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (limit + 3) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

    // SDRAM model, serves reads and programming writes
    initial begin
        bit          rd;
        logic [21:0] ma;
        int          lat;
        forever begin
            @(negedge clk);
            if (rst_n && (sdram_req || prog_we)) begin
                rd  = sdram_req;
                ma  = sdram_addr;
                lat = 1 + $unsigned($random(seed)) % 4;
                repeat (lat - 1) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                if (rd) begin
                    lat = $unsigned($random(seed)) % 3;
                    repeat (lat) @(negedge clk);
                    data_read = {16'(ma + 22'd1) ^ 16'ha5c3, ma[15:0] ^ 16'ha5c3};
                    data_rdy  = 1'b1;
                    @(negedge clk);
                    data_rdy = 1'b0;
                end
            end
        end
    end

    function automatic logic ok_of(input int i);
        case (i)
            0: return gfx1_ok;
            1: return gfx2_ok;
            2: return snd_ok;
            default: return main_ok;
        endcase
    endfunction

    task automatic set_slot(input int i, input logic cs, input logic [17:0] a);
        case (i)
            0: begin gfx1_cs = cs; gfx1_addr = a; end
            1: begin gfx2_cs = cs; gfx2_addr = a; end
            2: begin snd_cs = cs; snd_addr = a[14:0]; end
            default: begin main_cs = cs; main_addr = a[16:0]; end
        endcase
    endtask

    // Hold the request until ok, then drop cs for at least one cycle
    task automatic do_read(input int i, input logic [17:0] a);
        set_slot(i, 1'b1, a);
        do @(negedge clk); while (!ok_of(i));
        set_slot(i, 1'b0, a);
        @(negedge clk);
    endtask

    task automatic read_loop(input int i);
        logic [31:0] r;
        repeat (n_reads) begin
            r = $random(seed);
            repeat (r[9:8]) @(negedge clk);
            do_read(i, {10'd0, r[7:0]});   // Narrow range so lines get reused
        end
    endtask

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        while (prog_we) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic pulse_loop_rst();
        loop_rst = 1'b1;
        @(negedge clk);
        loop_rst = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic [17:0] a;
        seed = 32'hef55c670;
        {rst_n, downloading, loop_rst, ioctl_wr, sdram_ack, data_rdy} = '0;
        {gfx1_cs, gfx2_cs, snd_cs, main_cs} = '0;
        {gfx1_addr, gfx2_addr, snd_addr, main_addr} = '0;
        ioctl_addr = '0;
        ioctl_data = '0;
        data_read  = '0;
        phase      = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        phase = 1;
        repeat (12) @(negedge clk);

        phase       = 2;
        downloading = 1'b1;
        @(negedge clk);
        repeat (n_prog) begin
            r = $random(seed);
            load_byte(r[24:0] % prom_start, r[31:24]);
        end
        phase = 3;
        repeat (n_prom) begin
            r = $random(seed);
            load_byte(prom_start + 25'(r[15:0]), r[31:24]);
        end
        downloading = 1'b0;

        phase = 4;
        fork
            read_loop(0);
            read_loop(1);
            read_loop(2);
            read_loop(3);
        join
        repeat (8) @(negedge clk);

        phase = 5;
        for (int k = 0; k < n_line; k++) begin
            r = $random(seed);
            a = r[17:0] & ~18'd3;
            pulse_loop_rst();
            do_read(k % 4, a);
            do_read(k % 4, a | 18'd1);   // Same line, no fetch
            pulse_loop_rst();
            do_read(k % 4, a);
        end
        repeat (4) @(negedge clk);

        phase       = 6;
        downloading = 1'b1;
        repeat (n_dl) begin
            @(negedge clk);
            r = $random(seed);
            for (int i = 0; i < 4; i++) set_slot(i, r[i], r[25:8]);
        end
        for (int i = 0; i < 4; i++) set_slot(i, 1'b0, '0);
        @(negedge clk);
        phase       = 7;
        downloading = 1'b0;
        @(posedge clk);
        #1;
        $display("Tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/rom_pkg.sv
hdl/cen_gen.sv
hdl/rom_dwnld.sv
hdl/rom_slot.sv
hdl/rom_hub.sv
hdl/arcade_game.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f project.f --top-module tb_top -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF ">>> PASS"; then
    exit 0
fi
exit 1
